/* Bender.yml */
package:
  name: decode_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/decode_pkg.sv
      - decoder/instr_decoder.sv
      - logic/gpr_file.sv
      - logic/operand_gen.sv
      - logic/decode_pipe_reg.sv
      - logic/decode_stage.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_decode_stage.sv

/* common/decode_pkg.sv */
// Decode stage types
// Vector types for the datapath and enums for the decoded control fields

`default_nettype none

`include "decode_stage_config.svh"

package decode_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`ILEN-1:0]       instr_t;
  typedef logic [`GPR_ADDR_W-1:0] gpr_addr_t;

  // Major opcodes of the supported classes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [1:0] {RS1_DATA, CURRENT_PC, ZERO} op1_sel_e;

  typedef enum logic [1:0] {RS2_DATA, IMM_I, IMM_U, NEXT_PC} op2_sel_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // Branch compares
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Same encoding as load/store funct3
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } mem_size_e;

  typedef enum logic {WB_ALU, WB_LSU} wb_src_e;

endpackage

`default_nettype wire

/* common/decode_stage_config.svh */
// Decode stage configuration
// Widths fixed by the RV32I base ISA

`ifndef DECODE_STAGE_CONFIG_SVH
`define DECODE_STAGE_CONFIG_SVH

// Data word and PC width
`define XLEN 32

// Instruction word width
`define ILEN 32

// Register file geometry
`define GPR_ADDR_W 5
`define GPR_COUNT  32

`endif

/* decode_stage.f */
+incdir+common
common/decode_pkg.sv
decoder/instr_decoder.sv
logic/gpr_file.sv
logic/operand_gen.sv
logic/decode_pipe_reg.sv
logic/decode_stage.sv
verif/tb_decode_stage.sv

/* decoder/instr_decoder.sv */
// Instruction decoder
// Turns opcode, funct3 and funct7 of an RV32I instruction into
// operand selects, ALU operation, memory and write-back controls

`default_nettype none

module instr_decoder (
  input  decode_pkg::instr_t    instr_i,
  output logic                  rs1_re_o,
  output logic                  rs2_re_o,
  output decode_pkg::op1_sel_e  op1_sel_o,
  output decode_pkg::op2_sel_e  op2_sel_o,
  output decode_pkg::alu_op_e   alu_op_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output decode_pkg::mem_size_e mem_size_o,
  output logic                  load_o,
  output logic                  wb_we_o,
  output decode_pkg::wb_src_e   wb_src_o,
  output logic                  branch_o,
  output logic                  jal_o,
  output logic                  jalr_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  // funct7[5] selects SUB and SRA
  assign alt    = instr_i[30];

  function automatic decode_pkg::alu_op_e arith_op(logic [2:0] f3, logic sub_sra);
    case (f3)
      3'd0:    return sub_sra ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
      3'd1:    return decode_pkg::ALU_SLL;
      3'd2:    return decode_pkg::ALU_SLT;
      3'd3:    return decode_pkg::ALU_SLTU;
      3'd4:    return decode_pkg::ALU_XOR;
      3'd5:    return sub_sra ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
      3'd6:    return decode_pkg::ALU_OR;
      default: return decode_pkg::ALU_AND;
    endcase
  endfunction

  function automatic decode_pkg::alu_op_e branch_op(logic [2:0] f3);
    case (f3)
      3'd1:    return decode_pkg::ALU_NE;
      3'd4:    return decode_pkg::ALU_LT;
      3'd5:    return decode_pkg::ALU_GE;
      3'd6:    return decode_pkg::ALU_LTU;
      3'd7:    return decode_pkg::ALU_GEU;
      default: return decode_pkg::ALU_EQ;
    endcase
  endfunction

  assign mem_size_o = decode_pkg::mem_size_e'(funct3);
  assign load_o     = (opcode == decode_pkg::OPC_LOAD);

  always_comb begin
    rs1_re_o  = 1'b0;
    rs2_re_o  = 1'b0;
    op1_sel_o = decode_pkg::RS1_DATA;
    op2_sel_o = decode_pkg::RS2_DATA;
    alu_op_o  = decode_pkg::ALU_ADD;
    mem_req_o = 1'b0;
    mem_we_o  = 1'b0;
    wb_we_o   = 1'b0;
    wb_src_o  = decode_pkg::WB_ALU;
    branch_o  = 1'b0;
    jal_o     = 1'b0;
    jalr_o    = 1'b0;

    case (opcode)
      decode_pkg::OPC_OP: begin
        rs1_re_o = 1'b1;
        rs2_re_o = 1'b1;
        alu_op_o = arith_op(funct3, alt);
        wb_we_o  = 1'b1;
      end
      decode_pkg::OPC_OP_IMM: begin
        rs1_re_o  = 1'b1;
        op2_sel_o = decode_pkg::IMM_I;
        // No SUBI, only shifts look at funct7
        alu_op_o  = arith_op(funct3, alt & (funct3 == 3'd5));
        wb_we_o   = 1'b1;
      end
      decode_pkg::OPC_LOAD: begin
        rs1_re_o  = 1'b1;
        op2_sel_o = decode_pkg::IMM_I;
        mem_req_o = 1'b1;
        wb_we_o   = 1'b1;
        wb_src_o  = decode_pkg::WB_LSU;
      end
      decode_pkg::OPC_STORE: begin
        rs1_re_o  = 1'b1;
        rs2_re_o  = 1'b1;
        mem_req_o = 1'b1;
        mem_we_o  = 1'b1;
      end
      decode_pkg::OPC_LUI: begin
        op1_sel_o = decode_pkg::ZERO;
        op2_sel_o = decode_pkg::IMM_U;
        wb_we_o   = 1'b1;
      end
      decode_pkg::OPC_AUIPC: begin
        op1_sel_o = decode_pkg::CURRENT_PC;
        op2_sel_o = decode_pkg::IMM_U;
        wb_we_o   = 1'b1;
      end
      decode_pkg::OPC_BRANCH: begin
        rs1_re_o = 1'b1;
        rs2_re_o = 1'b1;
        alu_op_o = branch_op(funct3);
        branch_o = 1'b1;
      end
      decode_pkg::OPC_JAL: begin
        op1_sel_o = decode_pkg::ZERO;
        op2_sel_o = decode_pkg::NEXT_PC;
        wb_we_o   = 1'b1;
        jal_o     = 1'b1;
      end
      decode_pkg::OPC_JALR: begin
        rs1_re_o  = 1'b1;
        op2_sel_o = decode_pkg::NEXT_PC;
        wb_we_o   = 1'b1;
        jalr_o    = 1'b1;
      end
      default: ;
    endcase
  end

  // At most one control-flow class per instruction
  assert final ($onehot0({branch_o, jal_o, jalr_o}))
    else $error("instr_decoder: several control-flow strobes at once");

endmodule

`default_nettype wire

/* logic/decode_pipe_reg.sv */
// Decode to execute pipeline register
// Captures an accepted instruction when not stalled, kill drops valid

`default_nettype none

module decode_pipe_reg (
  input  logic                  clk_i,
  input  logic                  arstn_i,
  input  logic                  f_valid_i,
  input  logic                  cu_stall_f_i,
  input  logic                  cu_stall_d_i,
  input  logic                  cu_kill_d_i,
  input  decode_pkg::xlen_t     op1_i,
  input  decode_pkg::xlen_t     op2_i,
  input  decode_pkg::xlen_t     mem_addr_i,
  input  decode_pkg::xlen_t     mem_data_i,
  input  decode_pkg::xlen_t     target_pc_i,
  input  decode_pkg::xlen_t     next_pc_i,
  input  decode_pkg::alu_op_e   alu_op_i,
  input  logic                  mem_req_i,
  input  logic                  mem_we_i,
  input  decode_pkg::mem_size_e mem_size_i,
  input  logic                  wb_we_i,
  input  decode_pkg::gpr_addr_t rd_addr_i,
  input  decode_pkg::wb_src_e   wb_src_i,
  input  logic                  branch_i,
  input  logic                  jal_i,
  input  logic                  jalr_i,
  output logic                  d_valid_o,
  output decode_pkg::xlen_t     d_op1_o,
  output decode_pkg::xlen_t     d_op2_o,
  output decode_pkg::xlen_t     d_mem_addr_o,
  output decode_pkg::xlen_t     d_mem_data_o,
  output decode_pkg::xlen_t     d_target_pc_o,
  output decode_pkg::xlen_t     d_next_pc_o,
  output decode_pkg::alu_op_e   d_alu_op_o,
  output logic                  d_mem_req_o,
  output logic                  d_mem_we_o,
  output decode_pkg::mem_size_e d_mem_size_o,
  output logic                  d_wb_we_o,
  output decode_pkg::gpr_addr_t d_rd_addr_o,
  output decode_pkg::wb_src_e   d_wb_src_o,
  output logic                  d_branch_o,
  output logic                  d_jal_o,
  output logic                  d_jalr_o,
  output logic                  d_br_j_taken_o
);

  logic accept;
  logic load;

  assign accept = f_valid_i & ~cu_stall_f_i;
  assign load   = accept & ~cu_stall_d_i;

  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      d_valid_o <= 1'b0;
    end else if (cu_kill_d_i) begin
      d_valid_o <= 1'b0;
    end else if (!cu_stall_d_i) begin
      d_valid_o <= accept;
    end
  end

  // Control strobes
  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      d_mem_req_o    <= 1'b0;
      d_wb_we_o      <= 1'b0;
      d_branch_o     <= 1'b0;
      d_jal_o        <= 1'b0;
      d_jalr_o       <= 1'b0;
      d_br_j_taken_o <= 1'b0;
    end else if (load) begin
      d_mem_req_o    <= mem_req_i;
      d_wb_we_o      <= wb_we_i;
      d_branch_o     <= branch_i;
      d_jal_o        <= jal_i;
      d_jalr_o       <= jalr_i;
      d_br_j_taken_o <= jal_i | jalr_i;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      d_op1_o       <= op1_i;
      d_op2_o       <= op2_i;
      d_mem_addr_o  <= mem_addr_i;
      d_mem_data_o  <= mem_data_i;
      d_target_pc_o <= target_pc_i;
      d_next_pc_o   <= next_pc_i;
      d_alu_op_o    <= alu_op_i;
      d_mem_we_o    <= mem_we_i;
      d_mem_size_o  <= mem_size_i;
      d_rd_addr_o   <= rd_addr_i;
      d_wb_src_o    <= wb_src_i;
    end
  end

  kill_clears_valid: assert property (
    @(posedge clk_i) disable iff (!arstn_i) cu_kill_d_i |=> !d_valid_o
  ) else $error("decode_pipe_reg: valid set after kill");

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// RV32I decode stage
// Decodes the fetched instruction, reads the register file, prepares
// operands, memory access and target PC, registered for execute

`default_nettype none

module decode_stage (
  input  logic                  clk_i,
  input  logic                  arstn_i,
  input  logic                  cu_kill_d_i,
  input  logic                  cu_stall_d_i,
  input  logic                  cu_stall_f_i,
  input  decode_pkg::instr_t    f_instr_i,
  input  decode_pkg::xlen_t     f_current_pc_i,
  input  decode_pkg::xlen_t     f_next_pc_i,
  input  logic                  f_valid_i,
  input  logic                  m_gpr_wr_en_i,
  input  decode_pkg::gpr_addr_t m_gpr_wr_addr_i,
  input  decode_pkg::xlen_t     m_gpr_wr_data_i,
  output logic                  d_valid_o,
  output decode_pkg::xlen_t     d_op1_o,
  output decode_pkg::xlen_t     d_op2_o,
  output decode_pkg::alu_op_e   d_alu_operation_o,
  output logic                  d_mem_req_o,
  output logic                  d_mem_we_o,
  output decode_pkg::mem_size_e d_mem_size_o,
  output decode_pkg::xlen_t     d_mem_addr_o,
  output decode_pkg::xlen_t     d_mem_data_o,
  output logic                  d_gpr_wr_en_o,
  output decode_pkg::gpr_addr_t d_gpr_wr_addr_o,
  output decode_pkg::wb_src_e   d_gpr_src_sel_o,
  output logic                  d_branch_o,
  output logic                  d_jal_o,
  output logic                  d_jalr_o,
  output logic                  d_br_j_taken_o,
  output decode_pkg::xlen_t     d_target_pc_o,
  output decode_pkg::xlen_t     d_next_pc_o,
  output decode_pkg::gpr_addr_t f_cu_rs1_addr_o,
  output logic                  f_cu_rs1_req_o,
  output decode_pkg::gpr_addr_t f_cu_rs2_addr_o,
  output logic                  f_cu_rs2_req_o
);

  decode_pkg::op1_sel_e  op1_sel;
  decode_pkg::op2_sel_e  op2_sel;
  decode_pkg::alu_op_e   alu_op;
  decode_pkg::mem_size_e mem_size;
  decode_pkg::wb_src_e   wb_src;
  logic                  mem_req, mem_we, load, wb_we;
  logic                  branch, jal, jalr;
  decode_pkg::xlen_t     rs1_data, rs2_data;
  decode_pkg::xlen_t     op1, op2, mem_addr, mem_data, target_pc;

  // Source fields go straight to the control unit for hazard checks
  assign f_cu_rs1_addr_o = f_instr_i[19:15];
  assign f_cu_rs2_addr_o = f_instr_i[24:20];

  instr_decoder i_decoder (
    .instr_i    (f_instr_i),      .rs1_re_o  (f_cu_rs1_req_o),
    .rs2_re_o   (f_cu_rs2_req_o), .op1_sel_o (op1_sel),
    .op2_sel_o  (op2_sel),        .alu_op_o  (alu_op),
    .mem_req_o  (mem_req),        .mem_we_o  (mem_we),
    .mem_size_o (mem_size),       .load_o    (load),
    .wb_we_o    (wb_we),          .wb_src_o  (wb_src),
    .branch_o   (branch),         .jal_o     (jal),
    .jalr_o     (jalr)
  );

  gpr_file i_gpr (
    .clk_i     (clk_i),           .arstn_i   (arstn_i),
    .wr_en_i   (m_gpr_wr_en_i),   .wr_addr_i (m_gpr_wr_addr_i),
    .wr_data_i (m_gpr_wr_data_i), .r1_addr_i (f_instr_i[19:15]),
    .r2_addr_i (f_instr_i[24:20]), .r1_data_o (rs1_data),
    .r2_data_o (rs2_data)
  );

  operand_gen i_operands (
    .instr_i      (f_instr_i),      .current_pc_i (f_current_pc_i),
    .next_pc_i    (f_next_pc_i),    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),       .op1_sel_i    (op1_sel),
    .op2_sel_i    (op2_sel),        .load_i       (load),
    .branch_i     (branch),         .jal_i        (jal),
    .jalr_i       (jalr),           .op1_o        (op1),
    .op2_o        (op2),            .mem_addr_o   (mem_addr),
    .mem_data_o   (mem_data),       .target_pc_o  (target_pc)
  );

  decode_pipe_reg i_pipe (
    .clk_i        (clk_i),          .arstn_i       (arstn_i),
    .f_valid_i    (f_valid_i),      .cu_stall_f_i  (cu_stall_f_i),
    .cu_stall_d_i (cu_stall_d_i),   .cu_kill_d_i   (cu_kill_d_i),
    .op1_i        (op1),            .op2_i         (op2),
    .mem_addr_i   (mem_addr),       .mem_data_i    (mem_data),
    .target_pc_i  (target_pc),      .next_pc_i     (f_next_pc_i),
    .alu_op_i     (alu_op),         .mem_req_i     (mem_req),
    .mem_we_i     (mem_we),         .mem_size_i    (mem_size),
    .wb_we_i      (wb_we),          .rd_addr_i     (f_instr_i[11:7]),
    .wb_src_i     (wb_src),         .branch_i      (branch),
    .jal_i        (jal),            .jalr_i        (jalr),
    .d_valid_o    (d_valid_o),      .d_op1_o       (d_op1_o),
    .d_op2_o      (d_op2_o),        .d_mem_addr_o  (d_mem_addr_o),
    .d_mem_data_o (d_mem_data_o),   .d_target_pc_o (d_target_pc_o),
    .d_next_pc_o  (d_next_pc_o),    .d_alu_op_o    (d_alu_operation_o),
    .d_mem_req_o  (d_mem_req_o),    .d_mem_we_o    (d_mem_we_o),
    .d_mem_size_o (d_mem_size_o),   .d_wb_we_o     (d_gpr_wr_en_o),
    .d_rd_addr_o  (d_gpr_wr_addr_o), .d_wb_src_o   (d_gpr_src_sel_o),
    .d_branch_o   (d_branch_o),     .d_jal_o       (d_jal_o),
    .d_jalr_o     (d_jalr_o),       .d_br_j_taken_o (d_br_j_taken_o)
  );

endmodule

`default_nettype wire

/* logic/gpr_file.sv */
// General purpose register file
// 32 words, two combinational read ports, one write port
// x0 is never written and always reads zero

`default_nettype none

`include "decode_stage_config.svh"

module gpr_file (
  input  logic                  clk_i,
  input  logic                  arstn_i,
  input  logic                  wr_en_i,
  input  decode_pkg::gpr_addr_t wr_addr_i,
  input  decode_pkg::xlen_t     wr_data_i,
  input  decode_pkg::gpr_addr_t r1_addr_i,
  input  decode_pkg::gpr_addr_t r2_addr_i,
  output decode_pkg::xlen_t     r1_data_o,
  output decode_pkg::xlen_t     r2_data_o
);

  decode_pkg::xlen_t regs [`GPR_COUNT];

  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      for (int i = 0; i < `GPR_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // No bypass, a same-cycle write shows up next cycle
  assign r1_data_o = regs[r1_addr_i];
  assign r2_data_o = regs[r2_addr_i];

  x0_stays_zero: assert property (
    @(posedge clk_i) disable iff (!arstn_i) regs[0] == '0
  ) else $error("gpr_file: x0 holds a nonzero value");

endmodule

`default_nettype wire

/* logic/operand_gen.sv */
// Operand generator
// Builds the immediates, selects the execute operands and precomputes
// the memory address, store data and jump/branch target

`default_nettype none

`include "decode_stage_config.svh"

module operand_gen (
  input  decode_pkg::instr_t   instr_i,
  input  decode_pkg::xlen_t    current_pc_i,
  input  decode_pkg::xlen_t    next_pc_i,
  input  decode_pkg::xlen_t    rs1_data_i,
  input  decode_pkg::xlen_t    rs2_data_i,
  input  decode_pkg::op1_sel_e op1_sel_i,
  input  decode_pkg::op2_sel_e op2_sel_i,
  input  logic                 load_i,
  input  logic                 branch_i,
  input  logic                 jal_i,
  input  logic                 jalr_i,
  output decode_pkg::xlen_t    op1_o,
  output decode_pkg::xlen_t    op2_o,
  output decode_pkg::xlen_t    mem_addr_o,
  output decode_pkg::xlen_t    mem_data_o,
  output decode_pkg::xlen_t    target_pc_o
);

  decode_pkg::xlen_t imm_i;
  decode_pkg::xlen_t imm_s;
  decode_pkg::xlen_t imm_b;
  decode_pkg::xlen_t imm_u;
  decode_pkg::xlen_t imm_j;

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  assign imm_i = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{(`XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{(`XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                  instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'd0};
  assign imm_j = {{(`XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                  instr_i[20], instr_i[30:21], 1'b0};

  //////////////////////////////////////////////////
  // Operands and memory access
  //////////////////////////////////////////////////

  always_comb begin
    case (op1_sel_i)
      decode_pkg::RS1_DATA:   op1_o = rs1_data_i;
      decode_pkg::CURRENT_PC: op1_o = current_pc_i;
      default:                op1_o = '0;
    endcase
  end

  always_comb begin
    case (op2_sel_i)
      decode_pkg::RS2_DATA: op2_o = rs2_data_i;
      decode_pkg::IMM_I:    op2_o = imm_i;
      decode_pkg::IMM_U:    op2_o = imm_u;
      default:              op2_o = next_pc_i;
    endcase
  end

  assign mem_addr_o = op1_o + (load_i ? imm_i : imm_s);
  assign mem_data_o = op2_o;

  // Target PC, branch offset when nothing else applies
  always_comb begin
    case ({jalr_i, jal_i, branch_i})
      3'b100:  target_pc_o = op1_o + imm_i;
      3'b010:  target_pc_o = current_pc_i + imm_j;
      default: target_pc_o = current_pc_i + imm_b;
    endcase
  end

endmodule

`default_nettype wire

/* verif/tb_decode_stage.sv */
// Directed testbench for the RV32I decode stage
// Preloads registers through the write port, issues one instruction per check
// and compares the registered outputs with values built from the encodings

`default_nettype none

module tb_decode_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 20;

  logic clk_i, arstn_i, cu_kill_d_i, cu_stall_d_i, cu_stall_f_i, f_valid_i, m_gpr_wr_en_i;
  decode_pkg::instr_t    f_instr_i;
  decode_pkg::xlen_t     f_current_pc_i, f_next_pc_i, m_gpr_wr_data_i;
  decode_pkg::gpr_addr_t m_gpr_wr_addr_i;

  logic d_valid_o, d_mem_req_o, d_mem_we_o, d_gpr_wr_en_o, d_branch_o, d_jal_o, d_jalr_o;
  logic d_br_j_taken_o, f_cu_rs1_req_o, f_cu_rs2_req_o;
  decode_pkg::xlen_t     d_op1_o, d_op2_o, d_mem_addr_o, d_mem_data_o, d_target_pc_o;
  decode_pkg::xlen_t     d_next_pc_o;
  decode_pkg::alu_op_e   d_alu_operation_o;
  decode_pkg::mem_size_e d_mem_size_o;
  decode_pkg::gpr_addr_t d_gpr_wr_addr_o, f_cu_rs1_addr_o, f_cu_rs2_addr_o;
  decode_pkg::wb_src_e   d_gpr_src_sel_o;

  int test_errors, tests_passed, tests_failed;

  decode_stage dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Instruction encoders and immediates
  //////////////////////////////////////////////////

  function automatic decode_pkg::instr_t encode_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic decode_pkg::instr_t encode_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic decode_pkg::instr_t encode_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic decode_pkg::instr_t encode_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic decode_pkg::instr_t encode_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic decode_pkg::instr_t encode_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic decode_pkg::xlen_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic write_reg(input logic [4:0] addr, input decode_pkg::xlen_t data);
    @(posedge clk_i);
    m_gpr_wr_en_i   <= 1'b1;
    m_gpr_wr_addr_i <= addr;
    m_gpr_wr_data_i <= data;
    @(posedge clk_i);
    m_gpr_wr_en_i   <= 1'b0;
  endtask

  // Apply one instruction and wait for it on the d_* side
  task automatic issue(input decode_pkg::instr_t instr, input decode_pkg::xlen_t pc);
    int cycles;
    @(posedge clk_i);
    f_instr_i      <= instr;
    f_current_pc_i <= pc;
    f_next_pc_i    <= pc + 32'd4;
    f_valid_i      <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk_i);
      f_valid_i <= 1'b0;
      cycles++;
      @(negedge clk_i);
    end while (!d_valid_o && cycles < TIMEOUT);
    if (!d_valid_o) begin
      $display("Timeout: d_valid_o never rose after issuing instruction %h", instr);
      $display("TESTS FAILED");
      $finish;
    end else if (cycles != 1) begin
      $display("Latency error: d_valid_o rose after %0d cycles instead of 1", cycles);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("[ok]   %s", name);
    end else begin
      tests_failed++;
      $display("[fail] %s with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_alu();
    decode_pkg::xlen_t a, b, pc;
    decode_pkg::instr_t add_instr;
    logic [11:0] imm;
    a = $urandom();
    b = $urandom();
    imm = $urandom();
    pc = $urandom() & ~32'h3;
    add_instr = encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, decode_pkg::OPC_OP);
    write_reg(5'd1, a);
    write_reg(5'd2, b);
    // Hazard request outputs follow the fetch word within the cycle
    @(posedge clk_i);
    f_instr_i <= add_instr;
    @(negedge clk_i);
    check("f_cu_rs1_addr_o", f_cu_rs1_addr_o, 1);
    check("f_cu_rs2_addr_o", f_cu_rs2_addr_o, 2);
    check("f_cu_rs1_req_o", f_cu_rs1_req_o, 1);
    check("f_cu_rs2_req_o", f_cu_rs2_req_o, 1);
    issue(add_instr, pc);
    check("d_op1_o", d_op1_o, a);
    check("d_op2_o", d_op2_o, b);
    check("d_alu_operation_o", d_alu_operation_o, decode_pkg::ALU_ADD);
    check("d_gpr_wr_en_o", d_gpr_wr_en_o, 1);
    check("d_gpr_wr_addr_o", d_gpr_wr_addr_o, 3);
    check("d_gpr_src_sel_o", d_gpr_src_sel_o, decode_pkg::WB_ALU);
    issue(encode_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4, decode_pkg::OPC_OP), pc);
    check("d_alu_operation_o", d_alu_operation_o, decode_pkg::ALU_SUB);
    check("d_op2_o", d_op2_o, b);
    issue(encode_i(imm, 5'd1, 3'd2, 5'd5, decode_pkg::OPC_OP_IMM), pc);
    check("f_cu_rs2_req_o", f_cu_rs2_req_o, 0);
    check("d_op1_o", d_op1_o, a);
    check("d_op2_o", d_op2_o, sext12(imm));
    check("d_alu_operation_o", d_alu_operation_o, decode_pkg::ALU_SLT);
    check("d_gpr_wr_addr_o", d_gpr_wr_addr_o, 5);
    finish_test("register and immediate ALU");
  endtask

  task automatic test_upper_and_jal();
    decode_pkg::xlen_t pc;
    logic [19:0] u;
    logic [20:0] j;
    pc = $urandom() & ~32'h3;
    u = $urandom();
    j = $urandom() & ~21'h1;
    issue(encode_u(u, 5'd6, decode_pkg::OPC_LUI), pc);
    check("d_op1_o", d_op1_o, 0);
    check("d_op2_o", d_op2_o, {u, 12'h000});
    issue(encode_u(u, 5'd7, decode_pkg::OPC_AUIPC), pc);
    check("d_op1_o", d_op1_o, pc);
    check("d_op2_o", d_op2_o, {u, 12'h000});
    issue(encode_j(j, 5'd1), pc);
    check("d_op1_o", d_op1_o, 0);
    check("d_op2_o", d_op2_o, pc + 32'd4);
    check("d_target_pc_o", d_target_pc_o, pc + {{11{j[20]}}, j});
    check("d_jal_o", d_jal_o, 1);
    check("d_br_j_taken_o", d_br_j_taken_o, 1);
    check("d_next_pc_o", d_next_pc_o, pc + 32'd4);
    finish_test("LUI, AUIPC and JAL");
  endtask

  task automatic test_memory();
    decode_pkg::xlen_t a, b, pc;
    logic [11:0] imm;
    a = $urandom();
    b = $urandom();
    imm = $urandom();
    pc = $urandom() & ~32'h3;
    write_reg(5'd6, a);
    write_reg(5'd8, b);
    issue(encode_i(imm, 5'd6, 3'd2, 5'd9, decode_pkg::OPC_LOAD), pc);
    check("d_mem_req_o", d_mem_req_o, 1);
    check("d_mem_we_o", d_mem_we_o, 0);
    check("d_mem_size_o", d_mem_size_o, decode_pkg::LW);
    check("d_mem_addr_o", d_mem_addr_o, a + sext12(imm));
    check("d_gpr_src_sel_o", d_gpr_src_sel_o, decode_pkg::WB_LSU);
    issue(encode_s(imm, 5'd8, 5'd6, 3'd1), pc);
    check("d_mem_req_o", d_mem_req_o, 1);
    check("d_mem_we_o", d_mem_we_o, 1);
    check("d_mem_size_o", d_mem_size_o, decode_pkg::LH);
    check("d_mem_addr_o", d_mem_addr_o, a + sext12(imm));
    check("d_mem_data_o", d_mem_data_o, b);
    check("d_gpr_wr_en_o", d_gpr_wr_en_o, 0);
    finish_test("load and store");
  endtask

  task automatic test_branch_jalr();
    decode_pkg::xlen_t a, b, pc;
    logic [12:0] boff;
    logic [11:0] imm;
    a = $urandom();
    b = $urandom();
    boff = $urandom() & ~13'h1;
    imm = $urandom();
    pc = $urandom() & ~32'h3;
    write_reg(5'd6, a);
    write_reg(5'd8, b);
    issue(encode_b(boff, 5'd8, 5'd6, 3'd1), pc);
    check("d_target_pc_o", d_target_pc_o, pc + {{19{boff[12]}}, boff});
    check("d_branch_o", d_branch_o, 1);
    check("d_alu_operation_o", d_alu_operation_o, decode_pkg::ALU_NE);
    check("d_gpr_wr_en_o", d_gpr_wr_en_o, 0);
    check("d_br_j_taken_o", d_br_j_taken_o, 0);
    issue(encode_i(imm, 5'd6, 3'd0, 5'd1, decode_pkg::OPC_JALR), pc);
    check("d_target_pc_o", d_target_pc_o, a + sext12(imm));
    check("d_jalr_o", d_jalr_o, 1);
    check("d_br_j_taken_o", d_br_j_taken_o, 1);
    check("d_op2_o", d_op2_o, pc + 32'd4);
    finish_test("branch and JALR");
  endtask

  task automatic test_flow_control();
    decode_pkg::xlen_t a, b;
    a = $urandom();
    b = $urandom();
    write_reg(5'd12, a);
    write_reg(5'd13, b);
    @(posedge clk_i);
    f_instr_i      <= encode_r(7'h00, 5'd13, 5'd12, 3'd0, 5'd14, decode_pkg::OPC_OP);
    f_current_pc_i <= 32'h100;
    f_next_pc_i    <= 32'h104;
    f_valid_i      <= 1'b1;
    // ADD captured on this edge
    @(posedge clk_i);
    // A new instruction arrives while decode is stalled
    cu_stall_d_i <= 1'b1;
    f_instr_i    <= encode_u(20'h12345, 5'd15, decode_pkg::OPC_LUI);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check("d_valid_o", d_valid_o, 1);
    check("d_op1_o", d_op1_o, a);
    check("d_op2_o", d_op2_o, b);
    check("d_gpr_wr_addr_o", d_gpr_wr_addr_o, 14);
    @(posedge clk_i);
    cu_stall_d_i <= 1'b0;
    cu_kill_d_i  <= 1'b1;
    @(posedge clk_i);
    cu_kill_d_i  <= 1'b0;
    cu_stall_f_i <= 1'b1;
    @(negedge clk_i);
    check("d_valid_o", d_valid_o, 0);
    @(posedge clk_i);
    cu_stall_f_i <= 1'b0;
    f_valid_i    <= 1'b0;
    @(negedge clk_i);
    check("d_valid_o", d_valid_o, 0);
    finish_test("stall, kill and fetch stall");
  endtask

  task automatic test_register_file();
    decode_pkg::xlen_t old_val, new_val;
    old_val = $urandom();
    new_val = ~old_val;
    write_reg(5'd0, $urandom() | 32'h1);
    issue(encode_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd11, decode_pkg::OPC_OP), 32'h200);
    check("d_op1_o", d_op1_o, 0);
    check("d_op2_o", d_op2_o, 0);
    write_reg(5'd9, old_val);
    // Write and read of x9 meet on the same edge
    @(posedge clk_i);
    f_instr_i       <= encode_r(7'h00, 5'd0, 5'd9, 3'd0, 5'd10, decode_pkg::OPC_OP);
    f_valid_i       <= 1'b1;
    m_gpr_wr_en_i   <= 1'b1;
    m_gpr_wr_addr_i <= 5'd9;
    m_gpr_wr_data_i <= new_val;
    @(posedge clk_i);
    m_gpr_wr_en_i   <= 1'b0;
    @(negedge clk_i);
    check("d_op1_o", d_op1_o, old_val);
    @(posedge clk_i);
    f_valid_i       <= 1'b0;
    @(negedge clk_i);
    check("d_op1_o", d_op1_o, new_val);
    finish_test("register file x0 and write timing");
  endtask

  initial begin
    void'($urandom(36));
    arstn_i = 1'b0;
    cu_kill_d_i = 1'b0;
    cu_stall_d_i = 1'b0;
    cu_stall_f_i = 1'b0;
    f_valid_i = 1'b0;
    f_instr_i = '0;
    f_current_pc_i = '0;
    f_next_pc_i = '0;
    m_gpr_wr_en_i = 1'b0;
    m_gpr_wr_addr_i = '0;
    m_gpr_wr_data_i = '0;
    test_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check("d_valid_o", d_valid_o, 0);
    check("d_mem_req_o", d_mem_req_o, 0);
    check("d_gpr_wr_en_o", d_gpr_wr_en_o, 0);
    check("d_branch_o", d_branch_o, 0);
    check("d_jal_o", d_jal_o, 0);
    check("d_jalr_o", d_jalr_o, 0);
    check("d_br_j_taken_o", d_br_j_taken_o, 0);
    finish_test("reset state");
    @(posedge clk_i);
    arstn_i <= 1'b1;
    test_alu();
    test_upper_and_jal();
    test_memory();
    test_branch_jalr();
    test_flow_control();
    test_register_file();
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
